// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= spi_master_tb
RTL_TOP    ?= spi_master
FILELIST   ?= spi_master.f
BUILD_DIR  ?= obj_dir
BUILD_JOBS ?= 4
LOG        ?= sim.log
VFLAGS     ?= --timing --assert --timescale 1ns/100ps
PASS_MSG   ?= STATUS: PASS
FAIL_MSG   ?= STATUS: FAIL

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(BUILD_JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/spi_fifo.sv ====
`timescale 1ns/100ps

module spi_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [7:0]                  data_in,
    input  logic                        fifo_en,
    input  logic                        fifo_read,
    input  logic                        fifo_write,
    output logic [7:0]                  data_out,
    output logic [$clog2(FIFO_DEPTH):0] data_count,
    output logic                        fifo_full,
    output logic                        fifo_empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [7:0]       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic             do_push;
    logic             do_pop;

    assign fifo_empty = (data_count == '0);
    assign fifo_full  = (data_count == (PTR_W + 1)'(FIFO_DEPTH));

    // Requests that hit a full or empty buffer are dropped
    assign do_push = fifo_en && fifo_write && !fifo_full;
    assign do_pop  = fifo_en && fifo_read && !fifo_empty;

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            data_count <= '0;
            data_out   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            // Registered read port, data_out holds between pops
            if (do_pop) begin
                data_out <= mem[rd_ptr];
                rd_ptr   <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   data_count <= data_count + 1'b1;
                2'b01:   data_count <= data_count - 1'b1;
                default: data_count <= data_count;
            endcase
        end
    end

endmodule

// ==== hdl/spi_link_pkg.sv ====
package spi_link_pkg;

    // One frame is always a single byte
    localparam int SPI_WORD_W = 8;

    // Two SCLK edges per bit
    localparam int SPI_EDGES = 2 * SPI_WORD_W;

    // Frame sequencing of the shift engine
    typedef enum logic [1:0] {
        LINK_IDLE,
        LINK_LOAD,
        LINK_SHIFT,
        LINK_DONE
    } link_state_t;

    // Standard SPI modes, encoded as {cpol, cpha}
    typedef enum logic [1:0] {
        SPI_MODE0 = 2'b00,
        SPI_MODE1 = 2'b01,
        SPI_MODE2 = 2'b10,
        SPI_MODE3 = 2'b11
    } spi_mode_t;

endpackage

// ==== hdl/spi_master.sv ====
`timescale 1ns/100ps

module spi_master import spi_reg_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  logic [REG_ADDR_W-1:0] addr,
    input  logic [REG_DATA_W-1:0] wdata,
    input  logic                  miso,
    output logic [REG_DATA_W-1:0] rdata,
    output logic                  rd_valid,
    output logic                  sclk,
    output logic                  cs_n,
    output logic                  mosi
);

    // Register block controls
    logic       tx_push;
    logic [7:0] tx_wdata;
    logic       rx_pop;
    logic       fifo_en;
    logic       cpol;
    logic       cpha;
    logic [7:0] clkdiv;

    // FIFO status and data
    logic [7:0] tx_data;
    logic       tx_full;
    logic       tx_empty;
    logic [7:0] rx_data;
    logic       rx_full;
    logic       rx_empty;

    // Shift engine handshake
    logic       tx_pop;
    logic       rx_push;
    logic [7:0] rx_byte;
    logic       busy;

    spi_regs #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) spi_regs_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .addr     (addr),
        .wdata    (wdata),
        .tx_full  (tx_full),
        .tx_empty (tx_empty),
        .rx_full  (rx_full),
        .rx_empty (rx_empty),
        .rx_data  (rx_data),
        .busy     (busy),
        .rdata    (rdata),
        .rd_valid (rd_valid),
        .tx_push  (tx_push),
        .tx_wdata (tx_wdata),
        .rx_pop   (rx_pop),
        .fifo_en  (fifo_en),
        .cpol     (cpol),
        .cpha     (cpha),
        .clkdiv   (clkdiv)
    );

    // Core to shifter
    spi_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) tx_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (tx_wdata),
        .fifo_en    (fifo_en),
        .fifo_read  (tx_pop),
        .fifo_write (tx_push),
        .data_out   (tx_data),
        .data_count (),
        .fifo_full  (tx_full),
        .fifo_empty (tx_empty)
    );

    // Shifter to core
    spi_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) rx_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (rx_byte),
        .fifo_en    (fifo_en),
        .fifo_read  (rx_pop),
        .fifo_write (rx_push),
        .data_out   (rx_data),
        .data_count (),
        .fifo_full  (rx_full),
        .fifo_empty (rx_empty)
    );

    spi_shifter spi_shifter_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .fifo_en  (fifo_en),
        .cpol     (cpol),
        .cpha     (cpha),
        .clkdiv   (clkdiv),
        .tx_data  (tx_data),
        .tx_empty (tx_empty),
        .rx_full  (rx_full),
        .miso     (miso),
        .tx_pop   (tx_pop),
        .rx_push  (rx_push),
        .rx_byte  (rx_byte),
        .busy     (busy),
        .sclk     (sclk),
        .cs_n     (cs_n),
        .mosi     (mosi)
    );

endmodule

// ==== hdl/spi_reg_pkg.sv ====
package spi_reg_pkg;

    // Register bus widths
    localparam int REG_ADDR_W = 3;
    localparam int REG_DATA_W = 8;

    // Register map, anything else reads as zero
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_CTRL   = 3'd0,
        REG_CLKDIV = 3'd1,
        REG_STATUS = 3'd2,
        REG_TXDATA = 3'd3,
        REG_RXDATA = 3'd4
    } reg_addr_t;

    // CTRL fields
    localparam int CTRL_EN_BIT   = 0;
    localparam int CTRL_CPOL_BIT = 1;
    localparam int CTRL_CPHA_BIT = 2;

    // STATUS fields, overflow flags are sticky until a CTRL write
    localparam int STAT_TX_EMPTY_BIT = 0;
    localparam int STAT_TX_FULL_BIT  = 1;
    localparam int STAT_RX_EMPTY_BIT = 2;
    localparam int STAT_RX_FULL_BIT  = 3;
    localparam int STAT_BUSY_BIT     = 4;
    localparam int STAT_TX_OVF_BIT   = 5;
    localparam int STAT_RX_OVF_BIT   = 6;

endpackage

// ==== hdl/spi_regs.sv ====
`timescale 1ns/100ps

module spi_regs import spi_reg_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  logic [REG_ADDR_W-1:0] addr,
    input  logic [REG_DATA_W-1:0] wdata,
    input  logic                  tx_full,
    input  logic                  tx_empty,
    input  logic                  rx_full,
    input  logic                  rx_empty,
    input  logic [7:0]            rx_data,
    input  logic                  busy,
    output logic [REG_DATA_W-1:0] rdata,
    output logic                  rd_valid,
    output logic                  tx_push,
    output logic [7:0]            tx_wdata,
    output logic                  rx_pop,
    output logic                  fifo_en,
    output logic                  cpol,
    output logic                  cpha,
    output logic [7:0]            clkdiv
);

    reg_addr_t             bus_addr;
    reg_addr_t             rd_addr_s1;
    reg_addr_t             rd_addr_s2;
    logic                  rd_valid_s1;
    logic                  rd_valid_s2;
    logic                  tx_ovf;
    logic                  rx_ovf;
    logic [REG_DATA_W-1:0] status;
    logic [REG_DATA_W-1:0] rd_decode;
    logic [REG_DATA_W-1:0] rd_data_q;

    // FIFO full flag cannot be reached with a single entry
    if (FIFO_DEPTH < 2) begin : g_depth_check
        $error("spi_regs: FIFO_DEPTH must be at least 2");
    end

    assign bus_addr = reg_addr_t'(addr);

    always_comb begin
        status                    = '0;
        status[STAT_TX_EMPTY_BIT] = tx_empty;
        status[STAT_TX_FULL_BIT]  = tx_full;
        status[STAT_RX_EMPTY_BIT] = rx_empty;
        status[STAT_RX_FULL_BIT]  = rx_full;
        status[STAT_BUSY_BIT]     = busy;
        status[STAT_TX_OVF_BIT]   = tx_ovf;
        status[STAT_RX_OVF_BIT]   = rx_ovf;
    end

    // RXDATA is muxed in one stage later, once the pop has landed
    always_comb begin
        rd_decode = '0;
        case (rd_addr_s1)
            REG_CTRL: begin
                rd_decode[CTRL_EN_BIT]   = fifo_en;
                rd_decode[CTRL_CPOL_BIT] = cpol;
                rd_decode[CTRL_CPHA_BIT] = cpha;
            end
            REG_CLKDIV: rd_decode = clkdiv;
            REG_STATUS: rd_decode = status;
            default:    rd_decode = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_en     <= 1'b0;
            cpol        <= 1'b0;
            cpha        <= 1'b0;
            clkdiv      <= '0;
            tx_push     <= 1'b0;
            rx_pop      <= 1'b0;
            tx_ovf      <= 1'b0;
            rx_ovf      <= 1'b0;
            rd_valid_s1 <= 1'b0;
            rd_valid_s2 <= 1'b0;
            rd_valid    <= 1'b0;
            rd_addr_s1  <= REG_CTRL;
            rd_addr_s2  <= REG_CTRL;
        end else begin
            // Strobes are registered, FIFO acts one cycle after the access
            tx_push <= wr_en && (bus_addr == REG_TXDATA) && fifo_en;
            rx_pop  <= rd_en && (bus_addr == REG_RXDATA) && fifo_en;

            // Flag the exact strobe the FIFO ignores
            if (tx_push && tx_full) begin
                tx_ovf <= 1'b1;
            end
            if (rx_pop && rx_empty) begin
                rx_ovf <= 1'b1;
            end

            if (wr_en && bus_addr == REG_CTRL) begin
                fifo_en <= wdata[CTRL_EN_BIT];
                cpol    <= wdata[CTRL_CPOL_BIT];
                cpha    <= wdata[CTRL_CPHA_BIT];
                tx_ovf  <= 1'b0;
                rx_ovf  <= 1'b0;
            end
            if (wr_en && bus_addr == REG_CLKDIV) begin
                clkdiv <= wdata;
            end

            rd_valid_s1 <= rd_en;
            rd_addr_s1  <= bus_addr;
            rd_valid_s2 <= rd_valid_s1;
            rd_addr_s2  <= rd_addr_s1;
            rd_valid    <= rd_valid_s2;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && bus_addr == REG_TXDATA) begin
            tx_wdata <= wdata;
        end
        rd_data_q <= rd_decode;
        // rdata holds its value between reads
        if (rd_valid_s2) begin
            rdata <= (rd_addr_s2 == REG_RXDATA) ? rx_data : rd_data_q;
        end
    end

endmodule

// ==== hdl/spi_shifter.sv ====
`timescale 1ns/100ps

module spi_shifter import spi_link_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fifo_en,
    input  logic                  cpol,
    input  logic                  cpha,
    input  logic [7:0]            clkdiv,
    input  logic [SPI_WORD_W-1:0] tx_data,
    input  logic                  tx_empty,
    input  logic                  rx_full,
    input  logic                  miso,
    output logic                  tx_pop,
    output logic                  rx_push,
    output logic [SPI_WORD_W-1:0] rx_byte,
    output logic                  busy,
    output logic                  sclk,
    output logic                  cs_n,
    output logic                  mosi
);

    localparam int EDGE_W = $clog2(SPI_EDGES);

    link_state_t           state;
    link_state_t           state_next;
    spi_mode_t             mode;
    logic                  lead_sample;
    logic                  start;
    logic [7:0]            div_cnt;
    logic [EDGE_W-1:0]     edge_cnt;
    logic                  half_done;
    logic                  lead_edge;
    logic                  sample_now;
    logic                  shift_now;
    logic                  sclk_tgl;
    logic                  cs_q;
    logic [SPI_WORD_W-1:0] tx_sr;
    logic [SPI_WORD_W-1:0] rx_sr;

    assign mode = spi_mode_t'({cpol, cpha});

    // Which SCLK edge captures miso
    always_comb begin
        case (mode)
            SPI_MODE0, SPI_MODE2: lead_sample = 1'b1;
            SPI_MODE1, SPI_MODE3: lead_sample = 1'b0;
            default:              lead_sample = 1'b1;
        endcase
    end

    // Need a byte to send and room for the returned one
    assign start = fifo_en && !tx_empty && !rx_full;

    assign half_done  = (state == LINK_SHIFT) && (div_cnt == clkdiv);
    assign lead_edge  = ~edge_cnt[0];
    assign sample_now = half_done && (lead_edge == lead_sample);
    assign shift_now  = half_done && (lead_edge != lead_sample);

    always_comb begin
        state_next = state;
        case (state)
            LINK_IDLE: begin
                if (start) begin
                    state_next = LINK_LOAD;
                end
            end
            LINK_LOAD:  state_next = LINK_SHIFT;
            LINK_SHIFT: begin
                if (half_done && edge_cnt == EDGE_W'(SPI_EDGES - 1)) begin
                    state_next = LINK_DONE;
                end
            end
            LINK_DONE:  state_next = LINK_IDLE;
            default:    state_next = LINK_IDLE;
        endcase
    end

    // FIFO data_out is valid during LOAD, one cycle after the pop
    assign tx_pop  = (state == LINK_IDLE) && start;
    assign rx_push = (state == LINK_DONE);
    assign rx_byte = rx_sr;
    assign busy    = (state != LINK_IDLE);

    // SCLK rests at cpol and toggles only inside a frame
    assign sclk = cpol ^ sclk_tgl;
    assign cs_n = cs_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= LINK_IDLE;
            div_cnt  <= '0;
            edge_cnt <= '0;
            sclk_tgl <= 1'b0;
            cs_q     <= 1'b1;
            mosi     <= 1'b0;
        end else begin
            state <= state_next;
            // Select is low only for LOAD and SHIFT
            cs_q  <= !(state_next == LINK_LOAD || state_next == LINK_SHIFT);
            case (state)
                LINK_LOAD: begin
                    div_cnt  <= '0;
                    edge_cnt <= '0;
                    sclk_tgl <= 1'b0;
                    // First bit must be set up before the leading edge
                    if (lead_sample) begin
                        mosi <= tx_data[SPI_WORD_W-1];
                    end
                end
                LINK_SHIFT: begin
                    if (half_done) begin
                        div_cnt  <= '0;
                        edge_cnt <= edge_cnt + 1'b1;
                        sclk_tgl <= ~sclk_tgl;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                    if (shift_now) begin
                        mosi <= tx_sr[SPI_WORD_W-1];
                    end
                end
                default: begin
                    div_cnt <= '0;
                end
            endcase
        end
    end

    // Shift registers, MSB first in both directions
    always_ff @(posedge clk) begin
        if (state == LINK_LOAD) begin
            tx_sr <= lead_sample ? {tx_data[SPI_WORD_W-2:0], 1'b0} : tx_data;
        end else if (shift_now) begin
            tx_sr <= {tx_sr[SPI_WORD_W-2:0], 1'b0};
        end
        if (sample_now) begin
            rx_sr <= {rx_sr[SPI_WORD_W-2:0], miso};
        end
    end

endmodule

// ==== spi_master.f ====
hdl/spi_reg_pkg.sv
hdl/spi_link_pkg.sv
hdl/spi_fifo.sv
hdl/spi_shifter.sv
hdl/spi_regs.sv
hdl/spi_master.sv
tests/spi_master_assert.sv
tests/spi_master_tb.sv

// ==== tests/spi_master_assert.sv ====
`timescale 1ns/100ps

module spi_master_assert (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic cs_n,
    input logic sclk,
    input logic cpol,
    input logic tx_pop,
    input logic tx_empty,
    input logic rx_push,
    input logic rx_full
);

    // Failure total for the testbench summary
    int unsigned fail_count = 0;

    // Select only drops inside a frame
    cs_idle_chk: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> cs_n)
        else begin
            fail_count++;
            $error("cs_n low while the shifter is idle");
        end

    // Clock parks at its polarity between frames
    sclk_rest_chk: assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> (sclk == cpol))
        else begin
            fail_count++;
            $error("sclk differs from cpol while cs_n is high");
        end

    tx_pop_chk: assert property (@(posedge clk) disable iff (!rst_n) tx_pop |-> !tx_empty)
        else begin
            fail_count++;
            $error("tx_pop issued on an empty TX FIFO");
        end

    rx_push_chk: assert property (@(posedge clk) disable iff (!rst_n) rx_push |-> !rx_full)
        else begin
            fail_count++;
            $error("rx_push issued on a full RX FIFO");
        end

endmodule

bind spi_master spi_master_assert spi_master_assert_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .busy     (busy),
    .cs_n     (cs_n),
    .sclk     (sclk),
    .cpol     (cpol),
    .tx_pop   (tx_pop),
    .tx_empty (tx_empty),
    .rx_push  (rx_push),
    .rx_full  (rx_full)
);

// ==== tests/spi_master_tb.sv ====
`timescale 1ns/100ps

module spi_master_tb import spi_reg_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int FIFO_DEPTH  = 8;
    localparam int TOTAL_BYTES = 31;
    localparam int MAX_DIV     = 1;
    localparam int WATCHDOG_NS = TOTAL_BYTES * 18 * (MAX_DIV + 1) * CLK_PERIOD * 4 + 2000;
    localparam int POLL_LIMIT  = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  wr_en;
    logic                  rd_en;
    logic [REG_ADDR_W-1:0] addr;
    logic [REG_DATA_W-1:0] wdata;
    logic [REG_DATA_W-1:0] rdata;
    logic                  rd_valid;
    logic                  sclk;
    logic                  cs_n;
    logic                  mosi;
    logic [15:0]           lfsr;
    int                    err_count;
    int                    tests_run;
    int                    tests_failed;
    int                    cs_falls = 0;

    // Loopback so every byte sent comes back
    spi_master #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) spi_master_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .addr     (addr),
        .wdata    (wdata),
        .miso     (mosi),
        .rdata    (rdata),
        .rd_valid (rd_valid),
        .sclk     (sclk),
        .cs_n     (cs_n),
        .mosi     (mosi)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Frame starts seen on the select line
    always @(negedge cs_n) cs_falls++;

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [7:0] ctrl_value(input logic en, input logic pol, input logic pha);
        logic [7:0] v;
        v                = '0;
        v[CTRL_EN_BIT]   = en;
        v[CTRL_CPOL_BIT] = pol;
        v[CTRL_CPHA_BIT] = pha;
        return v;
    endfunction

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, err_count - errs_before);
        end
    endtask

    task automatic reg_write(input logic [2:0] a, input logic [7:0] d);
        @(negedge clk);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic reg_read(input logic [2:0] a, output logic [7:0] d);
        int waited;
        @(negedge clk);
        rd_en = 1'b1;
        addr  = a;
        @(negedge clk);
        rd_en  = 1'b0;
        waited = 0;
        while (!rd_valid && waited < POLL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_valid) begin
            $display("read of address %0d never returned rd_valid", a);
            err_count++;
        end
        // Two edges after the one that samples rd_en
        check("rd_valid latency", 8'(waited), 8'd2);
        d = rdata;
    endtask

    // Idle once nothing is moving and either TX drained or RX blocks it
    task automatic wait_idle();
        logic [7:0] st;
        int         polls;
        bit         idle;
        idle  = 1'b0;
        polls = 0;
        while (!idle && polls < POLL_LIMIT) begin
            reg_read(REG_STATUS, st);
            idle = !st[STAT_BUSY_BIT] && (st[STAT_TX_EMPTY_BIT] || st[STAT_RX_FULL_BIT]);
            polls++;
        end
        if (!idle) begin
            $display("shifter still busy after %0d status polls", POLL_LIMIT);
            err_count++;
        end
    endtask

    task automatic reset_state();
        logic [7:0] st;
        logic [7:0] exp;
        int         errs;
        errs                   = err_count;
        exp                    = '0;
        exp[STAT_TX_EMPTY_BIT] = 1'b1;
        exp[STAT_RX_EMPTY_BIT] = 1'b1;
        reg_read(REG_STATUS, st);
        check("status", st, exp);
        check("cs_n", 8'(cs_n), 8'd1);
        check("sclk", 8'(sclk), 8'd0);
        check("mosi", 8'(mosi), 8'd0);
        report_test("reset_state", errs);
    endtask

    task automatic single_byte_modes();
        logic [7:0] tx_byte;
        logic [7:0] got;
        int         errs;
        errs = err_count;
        reg_write(REG_CLKDIV, 8'd1);
        // Loop index is {cpol, cpha}
        for (int m = 0; m < 4; m++) begin
            reg_write(REG_CTRL, ctrl_value(1'b1, m[1], m[0]));
            next_byte(tx_byte);
            reg_write(REG_TXDATA, tx_byte);
            wait_idle();
            reg_read(REG_RXDATA, got);
            check($sformatf("rxdata mode %0d", m), got, tx_byte);
            check($sformatf("sclk mode %0d", m), 8'(sclk), 8'(m[1]));
            check($sformatf("cs_n mode %0d", m), 8'(cs_n), 8'd1);
        end
        report_test("single_byte_modes", errs);
    endtask

    task automatic burst_order();
        logic [7:0] sent [$];
        logic [7:0] b;
        logic [7:0] st;
        int         errs;
        errs = err_count;
        reg_write(REG_CLKDIV, 8'd0);
        reg_write(REG_CTRL, ctrl_value(1'b1, 1'b0, 1'b0));
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            next_byte(b);
            sent.push_back(b);
            reg_write(REG_TXDATA, b);
        end
        wait_idle();
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            reg_read(REG_RXDATA, b);
            check($sformatf("rxdata[%0d]", i), b, sent[i]);
        end
        reg_read(REG_STATUS, st);
        check("rx_empty", 8'(st[STAT_RX_EMPTY_BIT]), 8'd1);
        report_test("burst_order", errs);
    endtask

    task automatic overflow_stall();
        logic [7:0] sent [$];
        logic [7:0] b;
        logic [7:0] st;
        int         errs;
        errs = err_count;
        for (int i = 0; i < 2 * FIFO_DEPTH + 1; i++) begin
            next_byte(b);
            sent.push_back(b);
            reg_write(REG_TXDATA, b);
            // First batch lands in RX, the rest piles up in TX
            if (i == FIFO_DEPTH - 1) begin
                wait_idle();
            end
        end
        reg_read(REG_STATUS, st);
        check("tx_full", 8'(st[STAT_TX_FULL_BIT]), 8'd1);
        check("rx_full", 8'(st[STAT_RX_FULL_BIT]), 8'd1);
        check("busy", 8'(st[STAT_BUSY_BIT]), 8'd0);
        check("tx_overflow", 8'(st[STAT_TX_OVF_BIT]), 8'd1);
        for (int i = 0; i < 2 * FIFO_DEPTH; i++) begin
            // Stalled bytes flow once RX has room
            if (i == FIFO_DEPTH) begin
                wait_idle();
            end
            reg_read(REG_RXDATA, b);
            check($sformatf("rxdata[%0d]", i), b, sent[i]);
        end
        reg_write(REG_CTRL, ctrl_value(1'b1, 1'b0, 1'b0));
        reg_read(REG_STATUS, st);
        check("tx_overflow after ctrl write", 8'(st[STAT_TX_OVF_BIT]), 8'd0);
        check("rx_empty", 8'(st[STAT_RX_EMPTY_BIT]), 8'd1);
        report_test("overflow_stall", errs);
    endtask

    task automatic disabled_access();
        logic [7:0] b;
        logic [7:0] st;
        int         falls;
        int         errs;
        errs = err_count;
        // One received byte stays behind so a stray pop would empty RX
        next_byte(b);
        reg_write(REG_TXDATA, b);
        wait_idle();
        reg_write(REG_CTRL, ctrl_value(1'b0, 1'b0, 1'b0));
        falls = cs_falls;
        next_byte(b);
        reg_write(REG_TXDATA, b);
        reg_read(REG_STATUS, st);
        check("tx_empty", 8'(st[STAT_TX_EMPTY_BIT]), 8'd1);
        check("rx_empty before read", 8'(st[STAT_RX_EMPTY_BIT]), 8'd0);
        reg_read(REG_RXDATA, b);
        reg_read(REG_STATUS, st);
        check("rx_empty", 8'(st[STAT_RX_EMPTY_BIT]), 8'd0);
        check("rx_overflow", 8'(st[STAT_RX_OVF_BIT]), 8'd0);
        check("cs_n falls", 8'(cs_falls - falls), 8'd0);
        report_test("disabled_access", errs);
    endtask

    initial begin
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        rd_en        = 1'b0;
        addr         = '0;
        wdata        = '0;
        lfsr         = 16'd47;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_state();
        single_byte_modes();
        burst_order();
        overflow_stall();
        disabled_access();

        err_count += spi_master_inst.spi_master_assert_inst.fail_count;
        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_count,
                 spi_master_inst.spi_master_assert_inst.fail_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Run limit scales with the bytes moved at the slowest divider
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
